//--- logic/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam int    NUM_REGS = 32;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct field under OP_SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    // register write request, also used for forwarding
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    typedef struct packed {
        alu_op_t   alu_op;
        word_t     op_a;
        word_t     op_b;
        word_t     store_data;
        logic      is_load;
        logic      is_store;
        logic      we;
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        word_t     store_data;
        logic      is_load;
        logic      is_store;
        logic      we;
        reg_addr_t dest;
    } ex_mem_t;

    typedef wb_t mem_wb_t;

    typedef struct packed {
        logic hold_pc;
        logic hold_ifid;
        logic bubble_idex;
        logic freeze_all;
    } stall_t;

endpackage

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic              clk,
    input  logic              rst_n_i,
    input  cpu_pkg::stall_t   stall_i,
    input  logic              branch_taken_i,
    input  cpu_pkg::word_t    branch_target_i,
    input  cpu_pkg::word_t    rom_data_i,
    output cpu_pkg::word_t    rom_addr_o,
    output logic              rom_ce_o,
    output cpu_pkg::word_t    id_pc_o,
    output cpu_pkg::word_t    id_inst_o
);

    cpu_pkg::word_t pc;
    logic           ce;
    logic           pc_hold;
    logic           ifid_hold;

    assign pc_hold   = stall_i.hold_pc | stall_i.freeze_all;
    assign ifid_hold = stall_i.hold_ifid | stall_i.freeze_all;

    // fetch enable comes up one clock after reset release
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ce <= 1'b0;
            pc <= cpu_pkg::RESET_PC;
        end else begin
            ce <= 1'b1;
            if (ce && !pc_hold) begin
                if (branch_taken_i) begin
                    pc <= branch_target_i;
                end else begin
                    pc <= pc + 32'd4;
                end
            end
        end
    end

    // IF/ID register, NOP until fetch is running
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_pc_o   <= cpu_pkg::RESET_PC;
            id_inst_o <= '0;
        end else if (!ifid_hold) begin
            id_pc_o   <= pc;
            id_inst_o <= ce ? rom_data_i : '0;
        end
    end

    assign rom_addr_o = pc;
    assign rom_ce_o   = ce;

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst_n_i,
    input  cpu_pkg::reg_addr_t raddr1_i,
    input  cpu_pkg::reg_addr_t raddr2_i,
    input  cpu_pkg::wb_t       wb_i,
    output cpu_pkg::word_t     rdata1_o,
    output cpu_pkg::word_t     rdata2_o
);

    cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.addr != '0) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // $0 is hardwired, same-cycle write passes through
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (wb_i.we && wb_i.addr == raddr1_i) ? wb_i.data : regs[raddr1_i];

    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (wb_i.we && wb_i.addr == raddr2_i) ? wb_i.data : regs[raddr2_i];

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  cpu_pkg::word_t     pc_i,
    input  cpu_pkg::word_t     inst_i,
    input  cpu_pkg::word_t     rdata1_i,
    input  cpu_pkg::word_t     rdata2_i,
    output cpu_pkg::reg_addr_t raddr1_o,
    output cpu_pkg::reg_addr_t raddr2_o,
    input  cpu_pkg::wb_t       ex_fwd_i,
    input  logic               ex_is_load_i,
    input  cpu_pkg::wb_t       mem_fwd_i,
    input  logic               stall_bus_i,
    output logic               branch_taken_o,
    output cpu_pkg::word_t     branch_target_o,
    output cpu_pkg::stall_t    stall_o,
    output cpu_pkg::id_ex_t    id_ex_o
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::reg_addr_t rd;
    logic [15:0]        imm;
    cpu_pkg::word_t     imm_sext;
    cpu_pkg::word_t     imm_zext;
    cpu_pkg::word_t     rs_val;
    cpu_pkg::word_t     rt_val;
    logic               use_rs;
    logic               use_rt;
    logic               is_beq;
    logic               is_bne;
    logic               load_use;

    // newest producer wins: execute, then memory, then regfile
    function automatic cpu_pkg::word_t fwd_sel(
        input cpu_pkg::reg_addr_t addr,
        input cpu_pkg::word_t     rf_data,
        input cpu_pkg::wb_t       ex_fwd,
        input cpu_pkg::wb_t       mem_fwd
    );
        cpu_pkg::word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_fwd.we && ex_fwd.addr == addr) begin
            val = ex_fwd.data;
        end else if (mem_fwd.we && mem_fwd.addr == addr) begin
            val = mem_fwd.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign opcode   = inst_i[31:26];
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign imm      = inst_i[15:0];
    assign funct    = inst_i[5:0];
    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'h0000, imm};

    assign raddr1_o = rs;
    assign raddr2_o = rt;

    assign rs_val = fwd_sel(rs, rdata1_i, ex_fwd_i, mem_fwd_i);
    assign rt_val = fwd_sel(rt, rdata2_i, ex_fwd_i, mem_fwd_i);

    always_comb begin
        id_ex_o            = '0;
        id_ex_o.alu_op     = cpu_pkg::ALU_ADD;
        id_ex_o.op_a       = rs_val;
        id_ex_o.op_b       = rt_val;
        id_ex_o.store_data = rt_val;
        use_rs             = 1'b0;
        use_rt             = 1'b0;
        is_beq             = 1'b0;
        is_bne             = 1'b0;
        case (opcode)
            cpu_pkg::OP_SPECIAL: begin
                use_rs       = 1'b1;
                use_rt       = 1'b1;
                id_ex_o.we   = 1'b1;
                id_ex_o.dest = rd;
                case (funct)
                    cpu_pkg::FN_ADDU: id_ex_o.alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUBU: id_ex_o.alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND:  id_ex_o.alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:   id_ex_o.alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_XOR:  id_ex_o.alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::FN_SLT:  id_ex_o.alu_op = cpu_pkg::ALU_SLT;
                    default: begin
                        // unsupported funct, NOP included
                        use_rs       = 1'b0;
                        use_rt       = 1'b0;
                        id_ex_o.we   = 1'b0;
                        id_ex_o.dest = '0;
                    end
                endcase
            end
            cpu_pkg::OP_ADDIU: begin
                use_rs       = 1'b1;
                id_ex_o.op_b = imm_sext;
                id_ex_o.we   = 1'b1;
                id_ex_o.dest = rt;
            end
            cpu_pkg::OP_ORI: begin
                use_rs         = 1'b1;
                id_ex_o.alu_op = cpu_pkg::ALU_OR;
                id_ex_o.op_b   = imm_zext;
                id_ex_o.we     = 1'b1;
                id_ex_o.dest   = rt;
            end
            cpu_pkg::OP_LUI: begin
                id_ex_o.alu_op = cpu_pkg::ALU_LUI;
                id_ex_o.op_b   = imm_zext;
                id_ex_o.we     = 1'b1;
                id_ex_o.dest   = rt;
            end
            cpu_pkg::OP_LW: begin
                use_rs          = 1'b1;
                id_ex_o.op_b    = imm_sext;
                id_ex_o.is_load = 1'b1;
                id_ex_o.we      = 1'b1;
                id_ex_o.dest    = rt;
            end
            cpu_pkg::OP_SW: begin
                use_rs           = 1'b1;
                use_rt           = 1'b1;
                id_ex_o.op_b     = imm_sext;
                id_ex_o.is_store = 1'b1;
            end
            cpu_pkg::OP_BEQ: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                is_beq = 1'b1;
            end
            cpu_pkg::OP_BNE: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                is_bne = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // branch resolved here, delay slot is already in fetch
    assign branch_taken_o  = (is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val);
    assign branch_target_o = pc_i + 32'd4 + {{14{imm[15]}}, imm, 2'b00};

    // load in execute feeding a source of this instruction
    assign load_use = ex_is_load_i && ex_fwd_i.addr != '0 &&
                      ((use_rs && rs == ex_fwd_i.addr) || (use_rt && rt == ex_fwd_i.addr));

    // bus freeze overrides the load-use bubble
    assign stall_o.freeze_all  = stall_bus_i;
    assign stall_o.hold_pc     = load_use & ~stall_bus_i;
    assign stall_o.hold_ifid   = load_use & ~stall_bus_i;
    assign stall_o.bubble_idex = load_use & ~stall_bus_i;

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  cpu_pkg::id_ex_t  id_ex_i,
    output cpu_pkg::ex_mem_t ex_mem_o,
    output cpu_pkg::wb_t     fwd_o
);

    cpu_pkg::word_t result;

    always_comb begin
        case (id_ex_i.alu_op)
            cpu_pkg::ALU_ADD: result = id_ex_i.op_a + id_ex_i.op_b;
            cpu_pkg::ALU_SUB: result = id_ex_i.op_a - id_ex_i.op_b;
            cpu_pkg::ALU_AND: result = id_ex_i.op_a & id_ex_i.op_b;
            cpu_pkg::ALU_OR:  result = id_ex_i.op_a | id_ex_i.op_b;
            cpu_pkg::ALU_XOR: result = id_ex_i.op_a ^ id_ex_i.op_b;
            cpu_pkg::ALU_SLT: begin
                result = {31'd0, $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
            end
            cpu_pkg::ALU_LUI: result = id_ex_i.op_b << 16;
            default:          result = '0;
        endcase
    end

    // for LW/SW the ADD above is base plus offset
    assign ex_mem_o.result     = result;
    assign ex_mem_o.store_data = id_ex_i.store_data;
    assign ex_mem_o.is_load    = id_ex_i.is_load;
    assign ex_mem_o.is_store   = id_ex_i.is_store;
    assign ex_mem_o.we         = id_ex_i.we;
    assign ex_mem_o.dest       = id_ex_i.dest;

    // a load has no data yet, so it cannot forward from here
    assign fwd_o.we   = id_ex_i.we & ~id_ex_i.is_load;
    assign fwd_o.addr = id_ex_i.dest;
    assign fwd_o.data = result;

endmodule

//--- logic/pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // all-zero payload is a NOP
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (hold_i) begin
            q_o <= q_o;
        end else if (bubble_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  cpu_pkg::ex_mem_t ex_mem_i,
    input  cpu_pkg::word_t   ram_data_i,
    output cpu_pkg::word_t   ram_addr_o,
    output cpu_pkg::word_t   ram_data_o,
    output logic             ram_re_o,
    output logic             ram_we_o,
    output cpu_pkg::mem_wb_t mem_wb_o
);

    // RAM answers in the same cycle
    assign ram_addr_o = ex_mem_i.result;
    assign ram_data_o = ex_mem_i.store_data;
    assign ram_re_o   = ex_mem_i.is_load;
    assign ram_we_o   = ex_mem_i.is_store;

    // also the memory-stage forwarding value
    assign mem_wb_o.we   = ex_mem_i.we;
    assign mem_wb_o.addr = ex_mem_i.dest;
    assign mem_wb_o.data = ex_mem_i.is_load ? ram_data_i : ex_mem_i.result;

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic           clk,
    input  logic           rst_n_i,

    output cpu_pkg::word_t rom_addr_o,
    output logic           rom_ce_o,
    input  cpu_pkg::word_t rom_data_i,

    output cpu_pkg::word_t ram_addr_o,
    output cpu_pkg::word_t ram_data_o,
    output logic           ram_re_o,
    output logic           ram_we_o,
    input  cpu_pkg::word_t ram_data_i,

    input  logic           stall_bus_i
);

    cpu_pkg::stall_t    stall;
    logic               branch_taken;
    cpu_pkg::word_t     branch_target;

    cpu_pkg::word_t     id_pc;
    cpu_pkg::word_t     id_inst;

    cpu_pkg::reg_addr_t raddr1;
    cpu_pkg::reg_addr_t raddr2;
    cpu_pkg::word_t     rdata1;
    cpu_pkg::word_t     rdata2;

    cpu_pkg::id_ex_t    id_ex_d;
    cpu_pkg::id_ex_t    id_ex_q;
    cpu_pkg::ex_mem_t   ex_mem_d;
    cpu_pkg::ex_mem_t   ex_mem_q;
    cpu_pkg::mem_wb_t   mem_wb_d;
    cpu_pkg::mem_wb_t   mem_wb_q;
    cpu_pkg::wb_t       ex_fwd;

    // input side
    fetch_unit fetch_instance (
        .clk,
        .rst_n_i,
        .stall_i         (stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .rom_data_i,
        .rom_addr_o,
        .rom_ce_o,
        .id_pc_o         (id_pc),
        .id_inst_o       (id_inst)
    );

    // processing part
    decode_stage decode_instance (
        .pc_i            (id_pc),
        .inst_i          (id_inst),
        .rdata1_i        (rdata1),
        .rdata2_i        (rdata2),
        .raddr1_o        (raddr1),
        .raddr2_o        (raddr2),
        .ex_fwd_i        (ex_fwd),
        .ex_is_load_i    (id_ex_q.is_load),
        .mem_fwd_i       (mem_wb_d),
        .stall_bus_i,
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .stall_o         (stall),
        .id_ex_o         (id_ex_d)
    );

    reg_file reg_file_instance (
        .clk,
        .rst_n_i,
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .wb_i     (mem_wb_q),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    pipe_stage_reg #(.payload_t(cpu_pkg::id_ex_t)) idex_reg (
        .clk,
        .rst_n_i,
        .hold_i   (stall.freeze_all),
        .bubble_i (stall.bubble_idex),
        .d_i      (id_ex_d),
        .q_o      (id_ex_q)
    );

    execute_stage execute_instance (
        .id_ex_i  (id_ex_q),
        .ex_mem_o (ex_mem_d),
        .fwd_o    (ex_fwd)
    );

    // output side
    pipe_stage_reg #(.payload_t(cpu_pkg::ex_mem_t)) exmem_reg (
        .clk,
        .rst_n_i,
        .hold_i   (stall.freeze_all),
        .bubble_i (1'b0),
        .d_i      (ex_mem_d),
        .q_o      (ex_mem_q)
    );

    mem_stage mem_instance (
        .ex_mem_i   (ex_mem_q),
        .ram_data_i,
        .ram_addr_o,
        .ram_data_o,
        .ram_re_o,
        .ram_we_o,
        .mem_wb_o   (mem_wb_d)
    );

    pipe_stage_reg #(.payload_t(cpu_pkg::mem_wb_t)) memwb_reg (
        .clk,
        .rst_n_i,
        .hold_i   (stall.freeze_all),
        .bubble_i (1'b0),
        .d_i      (mem_wb_d),
        .q_o      (mem_wb_q)
    );

endmodule

//--- dv/cpu_ref_model.sv
`timescale 1ns/1ps

module cpu_ref_model;

    localparam int STEP_LIMIT = 120;

    logic [31:0] imem [64];
    logic [31:0] dmem [512];
    logic [31:0] regs [32];

    // expected bus traffic in program order
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic [31:0] exp_ld_addr [$];

    task automatic run();
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] ea;
        logic        taken;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        pc  = 32'd0;
        npc = 32'd4;
        for (int step = 0; step < STEP_LIMIT; step++) begin
            inst  = imem[pc[7:2]];
            a     = regs[inst[25:21]];
            b     = regs[inst[20:16]];
            sext  = {{16{inst[15]}}, inst[15:0]};
            ea    = a + sext;
            taken = 1'b0;
            case (inst[31:26])
                6'h00: begin
                    case (inst[5:0])
                        6'h21: regs[inst[15:11]] = a + b;
                        6'h23: regs[inst[15:11]] = a - b;
                        6'h24: regs[inst[15:11]] = a & b;
                        6'h25: regs[inst[15:11]] = a | b;
                        6'h26: regs[inst[15:11]] = a ^ b;
                        6'h2a: regs[inst[15:11]] = {31'd0, $signed(a) < $signed(b)};
                        default: begin
                        end
                    endcase
                end
                6'h09: regs[inst[20:16]] = ea;
                6'h0d: regs[inst[20:16]] = a | {16'h0000, inst[15:0]};
                6'h0f: regs[inst[20:16]] = {inst[15:0], 16'h0000};
                6'h23: begin
                    exp_ld_addr.push_back(ea);
                    regs[inst[20:16]] = dmem[ea[10:2]];
                end
                6'h2b: begin
                    exp_st_addr.push_back(ea);
                    exp_st_data.push_back(b);
                    dmem[ea[10:2]] = b;
                end
                6'h04: taken = (a == b);
                6'h05: taken = (a != b);
                default: begin
                end
            endcase
            regs[0] = 32'd0;
            // delay slot: the next sequential instruction always runs
            pc  = npc;
            npc = taken ? (pc + {sext[29:0], 2'b00}) : (npc + 32'd4);
        end
    endtask

endmodule

//--- dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int TIMEOUT_CYCLES = 3000;

    logic        clk;
    logic        rst_n_i;
    logic        stall_bus_i;
    logic [31:0] rom_addr_o;
    logic        rom_ce_o;
    logic [31:0] rom_data_i;
    logic [31:0] ram_addr_o;
    logic [31:0] ram_data_o;
    logic        ram_re_o;
    logic        ram_we_o;
    logic [31:0] ram_data_i;

    logic [31:0] rom [64];
    logic [31:0] ram [512];
    integer      seed;
    int          reset_errs;
    int          store_errs;
    int          load_errs;
    int          hold_errs;
    int          cycles;
    logic        rst_q = 1'b0;
    logic        prev_frozen = 1'b0;
    logic [31:0] prev_rom_addr;
    logic [31:0] prev_ram_addr;
    logic [31:0] prev_ram_data;
    logic [1:0]  prev_strobes;
    logic [31:0] exp_a;
    logic [31:0] exp_d;
    string       name;

    cpu_top dut0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rom_addr_o  (rom_addr_o),
        .rom_ce_o    (rom_ce_o),
        .rom_data_i  (rom_data_i),
        .ram_addr_o  (ram_addr_o),
        .ram_data_o  (ram_data_o),
        .ram_re_o    (ram_re_o),
        .ram_we_o    (ram_we_o),
        .ram_data_i  (ram_data_i),
        .stall_bus_i (stall_bus_i)
    );

    cpu_ref_model ref0 ();

    // asynchronous memories
    assign rom_data_i = rom_ce_o ? rom[rom_addr_o[7:2]] : 32'd0;
    assign ram_data_i = ram[ram_addr_o[10:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] encode_rtype(input logic [4:0] rs, input logic [4:0] rt,
                                                 input logic [4:0] rd, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // store address region tells which behavior a store belongs to
    function automatic string store_behavior(input logic [31:0] addr);
        case (addr[11:8])
            4'h1:    return "alu_forwarding";
            4'h2:    return "load_use";
            4'h3:    return "branch";
            default: return "bus_stall";
        endcase
    endfunction

    task automatic build_program();
        for (int i = 0; i < 64; i++) begin
            rom[i] = 32'd0;
        end
        rom[0]  = encode_itype(6'h0f, 5'd0, 5'd1, 16'h1234);
        rom[1]  = encode_itype(6'h0d, 5'd1, 5'd1, 16'h8678);
        rom[2]  = encode_itype(6'h09, 5'd0, 5'd2, 16'hfffd);
        rom[3]  = encode_rtype(5'd1, 5'd2, 5'd3, 6'h21);
        rom[4]  = encode_rtype(5'd3, 5'd1, 5'd4, 6'h23);
        rom[5]  = encode_rtype(5'd3, 5'd4, 5'd5, 6'h24);
        rom[6]  = encode_rtype(5'd5, 5'd2, 5'd6, 6'h25);
        rom[7]  = encode_rtype(5'd6, 5'd1, 5'd7, 6'h26);
        rom[8]  = encode_rtype(5'd2, 5'd1, 5'd8, 6'h2a);
        rom[9]  = encode_rtype(5'd1, 5'd2, 5'd9, 6'h2a);
        for (int i = 0; i < 7; i++) begin
            rom[10 + i] = encode_itype(6'h2b, 5'd0, 5'(3 + i), 16'(32'h100 + 4 * i));
        end
        rom[17] = encode_itype(6'h23, 5'd0, 5'd10, 16'h0200);
        rom[18] = encode_rtype(5'd10, 5'd1, 5'd11, 6'h21);
        rom[19] = encode_itype(6'h2b, 5'd0, 5'd11, 16'h0204);
        rom[20] = encode_itype(6'h23, 5'd0, 5'd12, 16'h0208);
        rom[21] = encode_itype(6'h2b, 5'd0, 5'd12, 16'h020c);
        // taken branch whose delay slot runs and whose fall-through is skipped
        rom[22] = encode_itype(6'h04, 5'd8, 5'd8, 16'h0002);
        rom[23] = encode_itype(6'h09, 5'd0, 5'd13, 16'h0055);
        rom[24] = encode_itype(6'h09, 5'd0, 5'd13, 16'h0077);
        rom[25] = encode_itype(6'h2b, 5'd0, 5'd13, 16'h0300);
        // not-taken branch whose target would skip the second ADDIU
        rom[26] = encode_itype(6'h05, 5'd1, 5'd1, 16'h0002);
        rom[27] = encode_itype(6'h09, 5'd0, 5'd14, 16'h0011);
        rom[28] = encode_itype(6'h09, 5'd14, 5'd14, 16'h0022);
        rom[29] = encode_itype(6'h2b, 5'd0, 5'd14, 16'h0304);
        rom[30] = encode_itype(6'h23, 5'd0, 5'd15, 16'h0210);
        rom[31] = encode_rtype(5'd15, 5'd15, 5'd16, 6'h21);
        rom[32] = encode_itype(6'h2b, 5'd0, 5'd16, 16'h0400);
        rom[33] = encode_itype(6'h09, 5'd16, 5'd17, 16'h0001);
        rom[34] = encode_itype(6'h2b, 5'd0, 5'd17, 16'h0404);
        rom[35] = encode_rtype(5'd17, 5'd7, 5'd18, 6'h26);
        rom[36] = encode_itype(6'h2b, 5'd0, 5'd18, 16'h0408);
        // park in a self loop
        rom[37] = encode_itype(6'h04, 5'd0, 5'd0, 16'hffff);
    endtask

    always @(posedge clk) begin
        rst_q <= rst_n_i;
        if (rst_n_i && ram_we_o && !stall_bus_i) begin
            ram[ram_addr_o[10:2]] <= ram_data_o;
        end
    end

    // reset values hold into the first cycle after release
    always @(posedge clk) begin
        if (!rst_n_i || !rst_q) begin
            assert (!rom_ce_o && !ram_we_o && !ram_re_o && rom_addr_o == 32'd0) else begin
                reset_errs++;
                $display("outputs not idle around reset at %0t", $time);
            end
        end
    end

    // completed stores and loads against the model queues
    always @(posedge clk) begin
        if (rst_n_i && ram_we_o && !stall_bus_i) begin
            if (ref0.exp_st_addr.size() == 0) begin
                store_errs++;
                $display("unexpected extra store to %h", ram_addr_o);
            end else begin
                exp_a = ref0.exp_st_addr.pop_front();
                exp_d = ref0.exp_st_data.pop_front();
                name  = store_behavior(exp_a);
                assert (ram_addr_o == exp_a) else begin
                    store_errs++;
                    $display("FAIL %s store address expected %h actual %h",
                             name, exp_a, ram_addr_o);
                end
                assert (ram_data_o == exp_d) else begin
                    store_errs++;
                    $display("FAIL %s store data expected %h actual %h",
                             name, exp_d, ram_data_o);
                end
            end
        end
        if (rst_n_i && ram_re_o && !stall_bus_i) begin
            if (ref0.exp_ld_addr.size() == 0) begin
                load_errs++;
                $display("unexpected extra load from %h", ram_addr_o);
            end else begin
                exp_a = ref0.exp_ld_addr.pop_front();
                assert (ram_addr_o == exp_a) else begin
                    load_errs++;
                    $display("FAIL load_use load address expected %h actual %h",
                             exp_a, ram_addr_o);
                end
            end
        end
    end

    // a frozen clock edge must leave the bus outputs unchanged
    always @(posedge clk) begin
        if (prev_frozen) begin
            assert (rom_addr_o == prev_rom_addr && ram_addr_o == prev_ram_addr &&
                    ram_data_o == prev_ram_data && {ram_re_o, ram_we_o} == prev_strobes) else begin
                hold_errs++;
                $display("bus outputs moved during a stall at %0t", $time);
            end
        end
        prev_frozen   <= rst_n_i && stall_bus_i;
        prev_rom_addr <= rom_addr_o;
        prev_ram_addr <= ram_addr_o;
        prev_ram_data <= ram_data_o;
        prev_strobes  <= {ram_re_o, ram_we_o};
    end

    initial begin
        rst_n_i     = 1'b0;
        stall_bus_i = 1'b0;
        seed        = 32'h5f44;
        reset_errs  = 0;
        store_errs  = 0;
        load_errs   = 0;
        hold_errs   = 0;
        build_program();
        for (int i = 0; i < 512; i++) begin
            ram[i] = {7'd0, i[8:0], 7'd0, i[8:0]} ^ 32'ha5a5_0f0f;
            ref0.dmem[i] = ram[i];
        end
        for (int i = 0; i < 64; i++) begin
            ref0.imem[i] = rom[i];
        end
        ref0.run();
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        repeat (30) @(negedge clk);
        // random bus stalls until every store has been seen
        cycles = 0;
        while (ref0.exp_st_addr.size() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            stall_bus_i = (($random(seed) & 7) < 3);
            cycles++;
        end
        stall_bus_i = 1'b0;
        if (cycles >= TIMEOUT_CYCLES) begin
            store_errs++;
            $display("timeout: %0d expected stores never appeared", ref0.exp_st_addr.size());
        end
        repeat (8) @(negedge clk);
        if (ref0.exp_ld_addr.size() != 0) begin
            load_errs++;
            $display("%0d expected loads never appeared", ref0.exp_ld_addr.size());
        end
        $display("errors: reset %0d store %0d load %0d hold %0d",
                 reset_errs, store_errs, load_errs, hold_errs);
        if (reset_errs + store_errs + load_errs + hold_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
logic/cpu_pkg.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/pipe_stage_reg.sv
logic/mem_stage.sv
logic/cpu_top.sv
dv/cpu_ref_model.sv
dv/cpu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f files.f -o cpu_sim \
    > build.log 2>&1 \
    && ./obj_dir/cpu_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q ">>> FAIL" sim.log && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
